//--- rtl/line_cfg_if.sv
`timescale 1ns/100ps
//////////////////////////////////////////////////
// Line format and divisor from the register block
//////////////////////////////////////////////////
interface line_cfg_if;
  import uart_pkg::*;

  word_len_t word_len;   // LCR[1:0]
  logic      stop2;      // Two stop bits
  logic      par_en;
  logic      par_even;
  logic      par_stick;
  divisor_t  divisor;

  // Register side drives the levels
  modport regs (
    output word_len,
    output stop2,
    output par_en,
    output par_even,
    output par_stick,
    output divisor
  );

  // Baud generator and serializer only read them
  modport tx (
    input word_len,
    input stop2,
    input par_en,
    input par_even,
    input par_stick,
    input divisor
  );

endinterface

//--- rtl/uart_16550_tx.sv
`timescale 1ns/100ps
//////////////////////////////////////////////////
// 16C550-style transmitter top level
//////////////////////////////////////////////////
module uart_16550_tx (
  input  logic                baudclk_96000kHz,
  input  logic                reset,
  input  logic                wr,
  input  logic                rd,
  input  uart_pkg::reg_addr_t addr,
  input  uart_pkg::byte_t     wdata,
  output uart_pkg::byte_t     rdata,
  output logic                tx,
  output logic                irq_n,
  output logic                rts_n,
  output logic                dtr_n
);
  import uart_pkg::*;

  byte_t push_data;
  byte_t head;
  logic  push;
  logic  pop;
  logic  fifo_empty;
  logic  tx_idle;
  logic  bit_tick;

  line_cfg_if cfg_if ();

  uart_host_regs u_regs (
    .baudclk_96000kHz (baudclk_96000kHz),
    .reset            (reset),
    .wr               (wr),
    .rd               (rd),
    .addr             (addr),
    .wdata            (wdata),
    .rdata            (rdata),
    .cfg              (cfg_if.regs),
    .push             (push),
    .push_data        (push_data),
    .fifo_empty       (fifo_empty),
    .tx_idle          (tx_idle),
    .irq_n            (irq_n),
    .rts_n            (rts_n),
    .dtr_n            (dtr_n)
  );

  // Full stays inside, pushes to a full FIFO are lost
  uart_tx_fifo u_fifo (
    .baudclk_96000kHz (baudclk_96000kHz),
    .reset            (reset),
    .push             (push),
    .push_data        (push_data),
    .pop              (pop),
    .head             (head),
    .empty            (fifo_empty),
    .full             ()
  );

  uart_baud_tick u_baud (
    .baudclk_96000kHz (baudclk_96000kHz),
    .reset            (reset),
    .cfg              (cfg_if.tx),
    .bit_tick         (bit_tick)
  );

  uart_tx_serializer u_ser (
    .baudclk_96000kHz (baudclk_96000kHz),
    .reset            (reset),
    .cfg              (cfg_if.tx),
    .bit_tick         (bit_tick),
    .fifo_empty       (fifo_empty),
    .head             (head),
    .pop              (pop),
    .tx               (tx),
    .idle             (tx_idle)
  );

endmodule

//--- rtl/uart_baud_tick.sv
`timescale 1ns/100ps
//////////////////////////////////////////////////
// Bit-period strobe from the divisor latch
//////////////////////////////////////////////////
module uart_baud_tick (
  input  logic    baudclk_96000kHz,
  input  logic    reset,
  line_cfg_if.tx  cfg,
  output logic    bit_tick
);
  import uart_pkg::*;

  localparam int CNT_W = $bits(divisor_t) + $clog2(BAUD_SCALE);

  logic [CNT_W-1:0] cnt;
  logic [CNT_W-1:0] last;
  divisor_t         div_q;

  // Period is divisor x BAUD_SCALE cycles
  assign last = CNT_W'(cfg.divisor) * CNT_W'(BAUD_SCALE) - 1'b1;

  always_ff @(posedge baudclk_96000kHz or negedge reset)
  begin
    if (!reset)
    begin
      cnt      <= '0;
      div_q    <= DIV_RESET;
      bit_tick <= 1'b0;
    end
    else
    begin
      div_q <= cfg.divisor;
      if (cfg.divisor != div_q)
      begin
        cnt      <= '0;        // Restart on a divisor write
        bit_tick <= 1'b0;
      end
      else if (cnt == last)
      begin
        cnt      <= '0;
        bit_tick <= 1'b1;
      end
      else
      begin
        cnt      <= cnt + 1'b1;
        bit_tick <= 1'b0;
      end
    end
  end

endmodule

//--- rtl/uart_host_regs.sv
`timescale 1ns/100ps
//////////////////////////////////////////////////
// Host register block: LCR, IER, MCR, divisor,
// LSR/IIR read mux and THR-empty interrupt
//////////////////////////////////////////////////
module uart_host_regs (
  input  logic                baudclk_96000kHz,
  input  logic                reset,
  input  logic                wr,
  input  logic                rd,
  input  uart_pkg::reg_addr_t addr,
  input  uart_pkg::byte_t     wdata,
  output uart_pkg::byte_t     rdata,
  line_cfg_if.regs            cfg,
  output logic                push,
  output uart_pkg::byte_t     push_data,
  input  logic                fifo_empty,
  input  logic                tx_idle,
  output logic                irq_n,
  output logic                rts_n,
  output logic                dtr_n
);
  import uart_pkg::*;

  byte_t lcr;
  byte_t ier;
  byte_t mcr;
  byte_t dll;
  byte_t dlm;
  byte_t lsr_val;
  byte_t iir_val;
  byte_t rd_mux;
  logic  dlab;
  logic  wr_thr;
  logic  wr_ier;
  logic  iir_rd;
  logic  fifo_empty_q;
  logic  thre_set;
  logic  thre_flag;

  assign dlab   = lcr[LCR_DLAB];
  assign wr_thr = wr && (addr == ADDR_THR_DLL) && !dlab;
  assign wr_ier = wr && (addr == ADDR_IER_DLM) && !dlab;
  assign iir_rd = rd && (addr == ADDR_IIR);

  // THR writes go straight into the FIFO
  assign push      = wr_thr;
  assign push_data = wdata;

  //////////////////////////////////////////////////
  // Writable registers
  //////////////////////////////////////////////////
  always_ff @(posedge baudclk_96000kHz or negedge reset)
  begin
    if (!reset)
    begin
      lcr <= LCR_RESET;
      ier <= '0;
      mcr <= '0;
      dll <= DIV_RESET[7:0];
      dlm <= DIV_RESET[15:8];
    end
    else if (wr)
    begin
      case (addr)
        ADDR_THR_DLL:
          if (dlab)
            dll <= wdata;
        ADDR_IER_DLM:
          if (dlab)
            dlm <= wdata;
          else
            ier <= wdata;
        ADDR_LCR: lcr <= wdata;
        ADDR_MCR: mcr <= wdata;
        default: ;             // IIR and LSR are read only
      endcase
    end
  end

  // Line format out to the transmit side
  assign cfg.word_len  = lcr[1:0];
  assign cfg.stop2     = lcr[LCR_STOP2];
  assign cfg.par_en    = lcr[LCR_PAR_EN];
  assign cfg.par_even  = lcr[LCR_EVEN];
  assign cfg.par_stick = lcr[LCR_STICK];
  assign cfg.divisor   = {dlm, dll};

  //////////////////////////////////////////////////
  // THR-empty interrupt
  //////////////////////////////////////////////////
  // FIFO just drained, or the interrupt was just enabled
  assign thre_set = (fifo_empty && !fifo_empty_q) ||
                    (wr_ier && wdata[IER_THRE] && !ier[IER_THRE]);

  always_ff @(posedge baudclk_96000kHz or negedge reset)
  begin
    if (!reset)
    begin
      fifo_empty_q <= 1'b1;
      thre_flag    <= 1'b0;
    end
    else
    begin
      fifo_empty_q <= fifo_empty;
      if (thre_set)
        thre_flag <= 1'b1;     // A new event wins over a clear
      else if (wr_thr || iir_rd)
        thre_flag <= 1'b0;
    end
  end

  assign irq_n = !(thre_flag && ier[IER_THRE] && mcr[MCR_OUT2]);
  assign rts_n = !mcr[MCR_RTS];
  assign dtr_n = !mcr[MCR_DTR];

  //////////////////////////////////////////////////
  // Read path
  //////////////////////////////////////////////////
  // Only THRE and TEMT exist in LSR
  assign lsr_val = LSR_IDLE & {1'b0, fifo_empty && tx_idle, fifo_empty, 5'b00000};
  assign iir_val = (thre_flag && ier[IER_THRE]) ? IIR_THRE_PENDING : IIR_IDLE;

  always_comb
  begin
    case (addr)
      ADDR_THR_DLL: rd_mux = dlab ? dll : 8'h00;  // No receiver behind RBR
      ADDR_IER_DLM: rd_mux = dlab ? dlm : ier;
      ADDR_IIR:     rd_mux = iir_val;
      ADDR_LCR:     rd_mux = lcr;
      ADDR_MCR:     rd_mux = mcr;
      ADDR_LSR:     rd_mux = lsr_val;
      default:      rd_mux = 8'h00;
    endcase
  end

  // Read data holds until the next strobe
  always_ff @(posedge baudclk_96000kHz or negedge reset)
  begin
    if (!reset)
      rdata <= '0;
    else if (rd)
      rdata <= rd_mux;
  end

endmodule

//--- rtl/uart_pkg.sv
//////////////////////////////////////////////////
// Shared types, register map, bit positions and
// reset values of the UART transmitter
//////////////////////////////////////////////////
package uart_pkg;

  typedef logic [2:0]  reg_addr_t;
  typedef logic [7:0]  byte_t;
  typedef logic [15:0] divisor_t;   // DLM:DLL
  typedef logic [1:0]  word_len_t;  // 0..3 selects 5..8 data bits

  //////////////////////////////////////////////////
  // Register offsets
  //////////////////////////////////////////////////
  localparam reg_addr_t ADDR_THR_DLL = 3'd0;  // DLL when DLAB set
  localparam reg_addr_t ADDR_IER_DLM = 3'd1;  // DLM when DLAB set
  localparam reg_addr_t ADDR_IIR     = 3'd2;  // Writes here are ignored
  localparam reg_addr_t ADDR_LCR     = 3'd3;
  localparam reg_addr_t ADDR_MCR     = 3'd4;
  localparam reg_addr_t ADDR_LSR     = 3'd5;

  // LCR fields
  localparam int LCR_DLAB   = 7;
  localparam int LCR_STICK  = 5;
  localparam int LCR_EVEN   = 4;
  localparam int LCR_PAR_EN = 3;
  localparam int LCR_STOP2  = 2;

  // IER and MCR fields
  localparam int IER_THRE = 1;
  localparam int MCR_OUT2 = 3;  // Gates the interrupt pin
  localparam int MCR_RTS  = 1;
  localparam int MCR_DTR  = 0;

  //////////////////////////////////////////////////
  // Timing and sizes
  //////////////////////////////////////////////////
  localparam int BAUD_SCALE    = 64;  // Clock cycles per bit at divisor 1
  localparam int TX_FIFO_DEPTH = 16;

  // Reset and idle values
  localparam byte_t    LCR_RESET = 8'h00;
  localparam divisor_t DIV_RESET = 16'h8060;
  localparam byte_t    LSR_IDLE  = 8'h60;  // THR empty, transmitter empty
  localparam byte_t    IIR_IDLE  = 8'hC1;  // FIFO mode, nothing pending

  localparam byte_t IIR_THRE_PENDING = 8'hC2;

endpackage

//--- rtl/uart_tx_fifo.sv
`timescale 1ns/100ps
//////////////////////////////////////////////////
// Transmit byte FIFO, host writes to serializer
//////////////////////////////////////////////////
module uart_tx_fifo (
  input  logic            baudclk_96000kHz,
  input  logic            reset,
  input  logic            push,
  input  uart_pkg::byte_t push_data,
  input  logic            pop,
  output uart_pkg::byte_t head,
  output logic            empty,
  output logic            full
);
  import uart_pkg::*;

  localparam int PTR_W = $clog2(TX_FIFO_DEPTH);
  localparam int CNT_W = PTR_W + 1;

  byte_t            mem [TX_FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             do_push;
  logic             do_pop;

  assign full    = (count == CNT_W'(TX_FIFO_DEPTH));
  assign empty   = (count == '0);
  assign do_push = push && !full;   // Host has no back-pressure
  assign do_pop  = pop && !empty;
  assign head    = mem[rd_ptr];     // First-word fall-through

  // Storage
  always_ff @(posedge baudclk_96000kHz)
  begin
    if (do_push)
      mem[wr_ptr] <= push_data;
  end

  //////////////////////////////////////////////////
  // Pointers and fill level
  //////////////////////////////////////////////////
  always_ff @(posedge baudclk_96000kHz or negedge reset)
  begin
    if (!reset)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (do_push)
        wr_ptr <= wr_ptr + 1'b1;  // Wraps at the power-of-two depth
      if (do_pop)
        rd_ptr <= rd_ptr + 1'b1;
      case ({do_push, do_pop})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: ;             // Both or neither leave the level unchanged
      endcase
    end
  end

endmodule

//--- rtl/uart_tx_serializer.sv
`timescale 1ns/100ps
//////////////////////////////////////////////////
// Frame builder and transmit shift register
//////////////////////////////////////////////////
module uart_tx_serializer (
  input  logic            baudclk_96000kHz,
  input  logic            reset,
  line_cfg_if.tx          cfg,
  input  logic            bit_tick,
  input  logic            fifo_empty,
  input  uart_pkg::byte_t head,
  output logic            pop,
  output logic            tx,
  output logic            idle
);
  import uart_pkg::*;

  localparam int FRAME_W = 11;   // 8 data, parity, 2 stop

  logic [FRAME_W-1:0] frame;
  logic [FRAME_W-1:0] shift_q;
  logic [3:0]         data_bits;
  logic [3:0]         frame_bits;
  logic [3:0]         bits_left;
  byte_t              data_mask;
  byte_t              data;
  logic               par_bit;
  logic               busy;

  //////////////////////////////////////////////////
  // Frame after the start bit, LSB first
  //////////////////////////////////////////////////
  always_comb
  begin
    data_bits = 4'd5 + 4'(cfg.word_len);
    data_mask = 8'hFF >> (2'd3 - cfg.word_len);
    data      = head & data_mask;

    if (cfg.par_stick)
      par_bit = !cfg.par_even;  // Mark when EVEN clear, space when set
    else if (cfg.par_even)
      par_bit = ^data;
    else
      par_bit = ~^data;

    // Ones above the data read as stop bits
    frame = {3'b111, data | ~data_mask};
    if (cfg.par_en)
      frame[data_bits] = par_bit;

    frame_bits = data_bits + 4'(cfg.par_en) + 4'(cfg.stop2) + 4'd1;
  end

  // Take the next byte only between frames
  assign pop  = bit_tick && (bits_left == 4'd0) && !fifo_empty;
  assign idle = !busy;

  //////////////////////////////////////////////////
  // Bit sequencing
  //////////////////////////////////////////////////
  always_ff @(posedge baudclk_96000kHz or negedge reset)
  begin
    if (!reset)
    begin
      tx        <= 1'b1;
      busy      <= 1'b0;
      bits_left <= '0;
    end
    else if (bit_tick)
    begin
      if (bits_left != 4'd0)
      begin
        tx        <= shift_q[0];
        bits_left <= bits_left - 1'b1;
      end
      else if (pop)
      begin
        tx        <= 1'b0;       // Start bit, back to back with the last stop
        busy      <= 1'b1;
        bits_left <= frame_bits;
      end
      else
      begin
        tx   <= 1'b1;
        busy <= 1'b0;            // Last stop bit has completed
      end
    end
  end

  always_ff @(posedge baudclk_96000kHz)
  begin
    if (pop)
      shift_q <= frame;
    else if (bit_tick)
      shift_q <= {1'b1, shift_q[FRAME_W-1:1]};
  end

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the UART transmitter testbench with Verilator

cd "$(dirname "$0")" || exit 1

echo "Building simulation"
verilator --binary --timing --assert \
  --top-module tb_uart \
  --Mdir obj_dir \
  -o sim_uart \
  -f src.f
status=$?
if [ $status -ne 0 ]; then
  echo "Build failed with status $status"
  exit $status
fi

echo "Running simulation"
./obj_dir/sim_uart
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation failed with status $status"
  exit $status
fi

echo "Simulation finished"
exit 0

//--- src.f
rtl/uart_pkg.sv
rtl/line_cfg_if.sv
rtl/uart_host_regs.sv
rtl/uart_tx_fifo.sv
rtl/uart_baud_tick.sv
rtl/uart_tx_serializer.sv
rtl/uart_16550_tx.sv
test/uart_assert.sv
test/tb_uart.sv

//--- test/tb_uart.sv
`timescale 1ns/100ps
//////////////////////////////////////////////////
// Testbench for the transmitter: register access,
// serial-line monitor, watchdog
//////////////////////////////////////////////////
module tb_uart;
  import uart_pkg::*;

  localparam int CYCLES_PER_BIT = 64;           // Bit length at divisor 1
  localparam int CLK_NS         = 20;
  localparam int N_FRAMES       = 45;
  localparam int MAX_BIT_NS     = 3 * CYCLES_PER_BIT * CLK_NS;
  localparam int WATCHDOG_NS    = N_FRAMES * 12 * MAX_BIT_NS + 400000;

  logic      baudclk_96000kHz;
  logic      reset;
  logic      wr;
  logic      rd;
  reg_addr_t addr;
  byte_t     wdata;
  byte_t     rdata;
  logic      tx;
  logic      irq_n;
  logic      rts_n;
  logic      dtr_n;

  byte_t       expq[$];     // Bytes still due on the line
  byte_t       cur_lcr;
  int          cur_div;
  int unsigned seed;
  time         last_start;  // Falling edge of the previous start bit
  logic        burst_mode;  // Frames are expected back to back

  uart_16550_tx UUT (
    .baudclk_96000kHz (baudclk_96000kHz),
    .reset            (reset),
    .wr               (wr),
    .rd               (rd),
    .addr             (addr),
    .wdata            (wdata),
    .rdata            (rdata),
    .tx               (tx),
    .irq_n            (irq_n),
    .rts_n            (rts_n),
    .dtr_n            (dtr_n)
  );

  always #(CLK_NS / 2) baudclk_96000kHz = ~baudclk_96000kHz;

  //////////////////////////////////////////////////
  function automatic byte_t next_random();
    seed = seed * 32'd1103515245 + 32'd12345;
    return seed[23:16];
  endfunction

  task automatic report_error(input string msg);
    $display("** Error at %0d ns: %s", $time, msg);
    $display("CHECKS FAILED");
    $fatal(1, "Stopping at first error");
  endtask

  task automatic write_reg(input reg_addr_t a, input byte_t d);
    @(negedge baudclk_96000kHz);
    wr    = 1'b1;
    addr  = a;
    wdata = d;
    @(negedge baudclk_96000kHz);
    wr    = 1'b0;
  endtask

  task automatic read_reg(input reg_addr_t a, output byte_t d);
    @(negedge baudclk_96000kHz);
    rd   = 1'b1;
    addr = a;
    @(negedge baudclk_96000kHz);
    rd   = 1'b0;
    d    = rdata;
  endtask

  task automatic check_reg(input reg_addr_t a, input byte_t exp, input string name);
    byte_t got;
    read_reg(a, got);
    assert (got == exp)
    else report_error($sformatf("%s read 0x%02h, expected 0x%02h", name, got, exp));
  endtask

  task automatic send_byte(input byte_t b);
    write_reg(ADDR_THR_DLL, b);
    expq.push_back(b);
  endtask

  // Polls LSR until the queue is drained and the line is quiet
  task automatic wait_idle();
    byte_t lsr;
    lsr = 8'h00;
    while (expq.size() != 0 || lsr[6:5] != 2'b11)
      read_reg(ADDR_LSR, lsr);
  endtask

  //////////////////////////////////////////////////
  // Serial-line monitor
  //////////////////////////////////////////////////
  task automatic check_frame();
    int    per;
    int    nbits;
    int    nstop;
    byte_t got;
    byte_t exp;
    byte_t mask;
    logic  par_got;
    logic  par_exp;
    per   = cur_div * CYCLES_PER_BIT;
    nbits = 5 + int'(cur_lcr[1:0]);
    nstop = cur_lcr[2] ? 2 : 1;
    mask  = byte_t'((9'h1 << nbits) - 9'h1);
    got   = 8'h00;
    repeat (per / 2) @(negedge baudclk_96000kHz);   // Middle of start bit
    assert (tx == 1'b0) else report_error("Start bit did not hold low");
    for (int i = 0; i < nbits; i++)
    begin
      repeat (per) @(negedge baudclk_96000kHz);
      got[i] = tx;                                    // LSB first
    end
    if (expq.size() == 0)
      report_error($sformatf("Unexpected frame with data 0x%02h", got));
    exp = expq.pop_front() & mask;
    assert (got == exp)
    else report_error($sformatf("Frame data 0x%02h, expected 0x%02h", got, exp));
    if (cur_lcr[3])
    begin
      repeat (per) @(negedge baudclk_96000kHz);
      par_got = tx;
      if (cur_lcr[5])
        par_exp = !cur_lcr[4];                        // Stick parity
      else if (cur_lcr[4])
        par_exp = ^exp;
      else
        par_exp = ~^exp;
      assert (par_got == par_exp)
      else report_error($sformatf("Parity bit %0b, expected %0b", par_got, par_exp));
    end
    for (int s = 0; s < nstop; s++)
    begin
      repeat (per) @(negedge baudclk_96000kHz);
      assert (tx == 1'b1) else report_error($sformatf("Stop bit %0d is low", s));
    end
  endtask

  initial
  begin
    wait (reset === 1'b0);
    wait (reset === 1'b1);
    forever
    begin
      @(negedge tx);
      // A burst of 8N1 frames leaves no idle bit between frames
      if (burst_mode && expq.size() < 16)
        assert ($time - last_start == 10 * cur_div * CYCLES_PER_BIT * CLK_NS)
        else report_error($sformatf("Frame spacing %0d ns, expected %0d ns",
                                    $time - last_start,
                                    10 * cur_div * CYCLES_PER_BIT * CLK_NS));
      last_start = $time;
      check_frame();
    end
  end

  initial
  begin
    #(WATCHDOG_NS);
    $display("CHECKS FAILED");
    $fatal(1, "Timeout: the tests did not finish in time");
  end

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////
  task automatic send_format(input byte_t lcr, input int n);
    write_reg(ADDR_LCR, lcr);
    cur_lcr = lcr;
    for (int i = 0; i < n; i++)
      send_byte(next_random());
    wait_idle();
  endtask

  initial
  begin
    byte_t b;
    baudclk_96000kHz = 1'b0;
    reset      = 1'b1;
    wr         = 1'b0;
    rd         = 1'b0;
    addr       = '0;
    wdata      = '0;
    seed       = 32'd96784;
    cur_lcr    = 8'h03;
    cur_div    = 1;
    last_start = 0;
    burst_mode = 1'b0;
    #1;
    reset = 1'b0;          // Falling edge starts the asynchronous reset
    repeat (16) @(posedge baudclk_96000kHz);
    @(negedge baudclk_96000kHz);
    reset = 1'b1;

    // Reset values
    assert (tx && irq_n && rts_n && dtr_n) else report_error("Outputs not high after reset");
    check_reg(ADDR_LCR, 8'h00, "LCR");
    check_reg(ADDR_LSR, 8'h60, "LSR");
    check_reg(ADDR_IIR, 8'hC1, "IIR");
    write_reg(ADDR_LCR, 8'h80);
    check_reg(ADDR_THR_DLL, 8'h60, "DLL");
    check_reg(ADDR_IER_DLM, 8'h80, "DLM");

    // 8N1 at divisor 1
    write_reg(ADDR_THR_DLL, 8'h01);
    write_reg(ADDR_IER_DLM, 8'h00);
    send_format(8'h03, 8);

    // Line formats
    send_format(8'h04, 3);   // 5 data, 2 stop
    send_format(8'h1A, 3);   // 7 data, even parity
    send_format(8'h09, 3);   // 6 data, odd parity
    send_format(8'h2B, 3);   // Stick parity, mark
    send_format(8'h3B, 3);   // Stick parity, space

    // FIFO ordering, burst lands between two bit ticks
    write_reg(ADDR_LCR, 8'h03);
    cur_lcr    = 8'h03;
    burst_mode = 1'b1;
    @(posedge UUT.bit_tick);
    for (int i = 0; i < 17; i++)
    begin
      @(negedge baudclk_96000kHz);
      b     = next_random();
      wr    = 1'b1;
      addr  = ADDR_THR_DLL;
      wdata = b;
      if (i < 16)
        expq.push_back(b);     // The 17th is dropped
    end
    @(negedge baudclk_96000kHz);
    wr = 1'b0;
    check_reg(ADDR_LSR, 8'h00, "LSR");   // FIFO holds data, nothing sent yet
    wait_idle();
    burst_mode = 1'b0;
    repeat (4 * CYCLES_PER_BIT) @(negedge baudclk_96000kHz);

    // Divisor 3
    write_reg(ADDR_LCR, 8'h83);
    write_reg(ADDR_THR_DLL, 8'h03);
    write_reg(ADDR_IER_DLM, 8'h00);
    check_reg(ADDR_THR_DLL, 8'h03, "DLL");
    check_reg(ADDR_IER_DLM, 8'h00, "DLM");
    cur_div = 3;
    send_format(8'h03, 3);

    // THR-empty interrupt and modem outputs
    write_reg(ADDR_MCR, 8'h0B);
    assert (!rts_n && !dtr_n) else report_error("rts_n/dtr_n not low with MCR 0x0B");
    write_reg(ADDR_IER_DLM, 8'h02);
    check_reg(ADDR_IIR, 8'hC2, "IIR");
    assert (irq_n) else report_error("irq_n still low after IIR read");
    check_reg(ADDR_IIR, 8'hC1, "IIR");
    send_byte(next_random());
    while (irq_n)
      @(negedge baudclk_96000kHz);
    check_reg(ADDR_IIR, 8'hC2, "IIR");
    assert (irq_n) else report_error("irq_n still low after IIR read");
    check_reg(ADDR_IIR, 8'hC1, "IIR");
    check_reg(ADDR_LSR, 8'h20, "LSR");   // THR empty, frame still on the line
    wait_idle();
    check_reg(ADDR_LSR, 8'h60, "LSR");

    // Pending interrupt with the pin gated off by OUT2
    write_reg(ADDR_MCR, 8'h02);
    assert (!rts_n && dtr_n) else report_error("rts_n/dtr_n wrong with MCR 0x02");
    send_byte(next_random());
    wait_idle();
    check_reg(ADDR_IIR, 8'hC2, "IIR");
    write_reg(ADDR_MCR, 8'h01);
    assert (rts_n && !dtr_n) else report_error("rts_n/dtr_n wrong with MCR 0x01");

    repeat (10) @(negedge baudclk_96000kHz);
    if (expq.size() == 0)
    begin
      $display("ALL CHECKS PASSED");
      $finish;
    end
    else
    begin
      $display("CHECKS FAILED");
      $fatal(1, "Bytes were written but never sent");
    end
  end

endmodule

//--- test/uart_assert.sv
`timescale 1ns/100ps
//////////////////////////////////////////////////
// Port checks bound to the transmitter top level
//////////////////////////////////////////////////
module uart_assert (
  input logic               baudclk_96000kHz,
  input logic               reset,
  input logic               tx,
  input logic               irq_n,
  input logic               rts_n,
  input logic               dtr_n,
  input logic               pop,
  input logic               bit_tick,
  input logic               out2,
  input uart_pkg::divisor_t divisor
);
  import uart_pkg::*;

  int unsigned start_age;   // Cycles into the current start bit
  int unsigned bit_len;

  assign bit_len = 32'(divisor) * 32'(BAUD_SCALE);

  always_ff @(posedge baudclk_96000kHz or negedge reset)
  begin
    if (!reset)
      start_age <= 0;
    else if (pop)
      start_age <= 1;               // Start bit goes out on this edge
    else if (start_age == bit_len)
      start_age <= 0;
    else if (start_age != 0)
      start_age <= start_age + 1;
  end

  //////////////////////////////////////////////////
  // Outputs idle while reset is held
  reset_outputs_high: assert property (@(posedge baudclk_96000kHz)
    !reset |-> (tx && irq_n && rts_n && dtr_n))
    else $error("Outputs not idle during reset");

  // Start bit stays low for the whole bit period
  start_bit_low: assert property (@(posedge baudclk_96000kHz) disable iff (!reset)
    (start_age != 0) |-> !tx)
    else $error("Start bit ended early");

  // And ends exactly on the next bit boundary
  start_bit_length: assert property (@(posedge baudclk_96000kHz) disable iff (!reset)
    (start_age == bit_len) |-> bit_tick)
    else $error("Start bit length differs from one bit period");

  irq_gated_by_out2: assert property (@(posedge baudclk_96000kHz) disable iff (!reset)
    !out2 |-> irq_n)
    else $error("irq_n low while MCR OUT2 is clear");

endmodule

bind uart_16550_tx uart_assert u_assert (
  .baudclk_96000kHz (baudclk_96000kHz),
  .reset            (reset),
  .tx               (tx),
  .irq_n            (irq_n),
  .rts_n            (rts_n),
  .dtr_n            (dtr_n),
  .pop              (pop),
  .bit_tick         (bit_tick),
  .out2             (u_regs.mcr[3]),
  .divisor          (cfg_if.divisor)
);
